/* src/ethRxPkg.sv */
/*
   Shared constants, state encoding and output records for the MII receive MAC.
   Every RTL file refers to these by scoped names.
*/
package ethRxPkg;

   ////////////////////
   // Wire constants
   ////////////////////

   localparam logic [3:0] PreambleNibble = 4'h5;   // Repeated preamble nibble
   localparam logic [3:0] SfdNibble      = 4'hD;   // Second nibble of the SFD

   // CRC-32 in MSB-first register form, bits fed in wire order
   localparam logic [31:0] CrcPoly    = 32'h04C11DB7;
   localparam logic [31:0] CrcResidue = 32'hC704DD7B;   // Register after data plus good FCS

   // Credits the consumer grants after reset
   localparam logic [3:0] RxCredits = 4'd8;

   ////////////////////
   // Frame counting
   ////////////////////

   typedef logic [15:0] ByteCount_t;

   // Destination address through FCS
   localparam ByteCount_t MaxFrameLen = 16'd1518;
   localparam ByteCount_t AddrBytes   = 16'd6;      // Destination address length

   ////////////////////
   // Receive states
   ////////////////////

   typedef enum logic [1:0]
   {
      Idle,       // Waiting for carrier
      Preamble,   // Checking 5 nibbles until the SFD
      Data,       // Destination address through FCS
      Drop        // Discard until carrier drops
   } RxState_t;

   ////////////////////
   // Output records
   ////////////////////

   // One byte on the output stream
   typedef struct packed
   {
      logic [7:0] data;
      logic       startFrm;   // First byte of the frame
   } RxByte_t;

   // End of frame report
   typedef struct packed
   {
      logic       crcError;
      logic       addressMiss;
      logic       overrun;      // At least one byte lost for lack of credit
      logic       rxErr;        // MRxErr seen during data
      logic       tooLong;
      ByteCount_t byteCount;
   } RxStatus_t;

endpackage

/* src/rxStateMachine.sv */
/*
   Receive FSM. Checks preamble and SFD nibbles, limits the frame length and
   marks the end of every frame that reached the data state.
*/
`timescale 1ns/1ps

module rxStateMachine (
   input  logic                 MRxClk,
   input  logic                 Resetn,
   input  logic                 MRxDV,
   input  logic [3:0]           MRxD,
   input  logic                 MRxErr,
   input  ethRxPkg::ByteCount_t ByteCnt,
   output ethRxPkg::RxState_t   State,
   output logic                 FrameEnd,   // One cycle, first Idle cycle after a frame
   output logic                 TooLong
);

   always_ff @(posedge MRxClk or negedge Resetn)
   begin
      if (!Resetn)
      begin
         State    <= ethRxPkg::Idle;
         FrameEnd <= 1'b0;
         TooLong  <= 1'b0;
      end
      else
      begin
         FrameEnd <= 1'b0;
         case (State)
            ethRxPkg::Idle:
               if (MRxDV)
               begin
                  TooLong <= 1'b0;   // New carrier, forget the last frame
                  if (MRxD == ethRxPkg::PreambleNibble && !MRxErr)
                     State <= ethRxPkg::Preamble;
                  else
                     State <= ethRxPkg::Drop;
               end

            ethRxPkg::Preamble:
               if (!MRxDV)
                  State <= ethRxPkg::Idle;   // Carrier lost before SFD
               else if (MRxErr)
                  State <= ethRxPkg::Drop;
               else if (MRxD == ethRxPkg::SfdNibble)
                  State <= ethRxPkg::Data;
               else if (MRxD != ethRxPkg::PreambleNibble)
                  State <= ethRxPkg::Drop;

            ethRxPkg::Data:
               if (!MRxDV)
               begin
                  State    <= ethRxPkg::Idle;
                  FrameEnd <= 1'b1;
               end
               else if (ByteCnt == ethRxPkg::MaxFrameLen)
               begin
                  State   <= ethRxPkg::Drop;   // Rest of the frame is discarded
                  TooLong <= 1'b1;
               end

            ethRxPkg::Drop:
               if (!MRxDV)
               begin
                  State <= ethRxPkg::Idle;
                  // Only the length limit leads here from Data
                  FrameEnd <= TooLong;
               end

            default:
               State <= ethRxPkg::Idle;
         endcase
      end
   end

endmodule

/* src/rxByteCounter.sv */
/*
   Nibble phase and completed byte count of the frame in progress.
   Both clear while the receiver is idle.
*/
`timescale 1ns/1ps

module rxByteCounter (
   input  logic                 MRxClk,
   input  logic                 Resetn,
   input  logic                 MRxDV,
   input  ethRxPkg::RxState_t   State,
   output logic                 NibblePhase,   // High on the high nibble
   output logic                 ByteDone,
   output ethRxPkg::ByteCount_t ByteCnt
);

   logic dataNibble;

   assign dataNibble = (State == ethRxPkg::Data) && MRxDV;
   assign ByteDone   = dataNibble && NibblePhase;   // Edge samples the high nibble

   always_ff @(posedge MRxClk or negedge Resetn)
   begin
      if (!Resetn)
      begin
         NibblePhase <= 1'b0;
         ByteCnt     <= '0;
      end
      else if (State == ethRxPkg::Idle)
      begin
         NibblePhase <= 1'b0;
         ByteCnt     <= '0;
      end
      else if (dataNibble)
      begin
         NibblePhase <= ~NibblePhase;
         if (NibblePhase)
            ByteCnt <= ByteCnt + 16'd1;
      end
   end

endmodule

/* src/rxCrcCheck.sv */
/*
   Nibble-wide CRC-32 over the frame from the destination address through
   the FCS. CrcOk is high when the register holds the good-frame residue.
*/
`timescale 1ns/1ps

module rxCrcCheck (
   input  logic               MRxClk,
   input  logic               Resetn,
   input  logic [3:0]         MRxD,
   input  logic               MRxDV,
   input  ethRxPkg::RxState_t State,
   output logic               CrcOk
);

   logic [31:0] crcReg;

   // Four serial steps, MRxD[0] is first on the wire
   function automatic logic [31:0] crcNibble(input logic [31:0] crcIn, input logic [3:0] nib);
      logic [31:0] c;
      logic        feedback;
      c = crcIn;
      for (int i = 0; i < 4; i++)
      begin
         feedback = c[31] ^ nib[i];
         c = {c[30:0], 1'b0};
         if (feedback)
            c = c ^ ethRxPkg::CrcPoly;
      end
      return c;
   endfunction

   always_ff @(posedge MRxClk or negedge Resetn)
   begin
      if (!Resetn)
         crcReg <= '1;
      else if (State == ethRxPkg::Preamble)
         crcReg <= '1;                          // Preset before the first data nibble
      else if (State == ethRxPkg::Data && MRxDV)
         crcReg <= crcNibble(crcReg, MRxD);
   end

   assign CrcOk = (crcReg == ethRxPkg::CrcResidue);

endmodule

/* src/rxAddressFilter.sv */
/*
   Destination address filter. Compares the first six bytes against the
   station address and broadcast, and gives the accept decision after byte six.
*/
`timescale 1ns/1ps

module rxAddressFilter (
   input  logic                 MRxClk,
   input  logic                 Resetn,
   input  ethRxPkg::RxState_t   State,
   input  logic                 ByteDone,
   input  ethRxPkg::ByteCount_t ByteCnt,
   input  logic [7:0]           AssembledByte,
   input  logic [47:0]          Mac,
   input  logic                 Promiscuous,
   input  logic                 BroadcastDisable,
   output logic                 AddrMiss
);

   logic [7:0][7:0] macBytes;     // Padded to eight so any 3-bit index is valid
   logic [7:0]      macByte;
   logic            addrByte;
   logic            macMatch;
   logic            bcastMatch;
   logic            macMatchNext;
   logic            bcastMatchNext;

   assign macBytes = {16'h0000, Mac};
   assign macByte  = macBytes[ByteCnt[2:0]];
   assign addrByte = ByteDone && (ByteCnt < ethRxPkg::AddrBytes);

   assign macMatchNext   = macMatch && (AssembledByte == macByte);
   assign bcastMatchNext = bcastMatch && (AssembledByte == 8'hFF);

   always_ff @(posedge MRxClk or negedge Resetn)
   begin
      if (!Resetn)
      begin
         macMatch   <= 1'b1;
         bcastMatch <= 1'b1;
         AddrMiss   <= 1'b0;
      end
      else if (State == ethRxPkg::Preamble)
      begin
         macMatch   <= 1'b1;   // Frame start
         bcastMatch <= 1'b1;
         AddrMiss   <= 1'b0;
      end
      else if (addrByte)
      begin
         macMatch   <= macMatchNext;
         bcastMatch <= bcastMatchNext;
         if (ByteCnt == ethRxPkg::AddrBytes - 16'd1)   // Last address byte
            AddrMiss <= !(macMatchNext || (bcastMatchNext && !BroadcastDisable) || Promiscuous);
      end
   end

endmodule

/* src/rxByteStream.sv */
/*
   Byte assembly and the credit-controlled output stream. Bytes pass two
   register stages, a byte without credit is dropped and the frame flagged.
*/
`timescale 1ns/1ps

module rxByteStream (
   input  logic                 MRxClk,
   input  logic                 Resetn,
   input  logic [3:0]           MRxD,
   input  logic                 MRxErr,
   input  ethRxPkg::RxState_t   State,
   input  logic                 NibblePhase,
   input  logic                 ByteDone,
   input  ethRxPkg::ByteCount_t ByteCnt,
   input  logic                 FrameEnd,
   input  logic                 CrcOk,
   input  logic                 AddrMiss,
   input  logic                 TooLong,
   input  logic                 CreditReturn,
   output logic [7:0]           AssembledByte,
   output logic                 RxValid,
   output ethRxPkg::RxByte_t    RxByte,
   output logic                 StatusValid,
   output ethRxPkg::RxStatus_t  RxStatus
);

   logic [3:0]          lowNibble;
   logic                stage1Valid;
   ethRxPkg::RxByte_t   stage1Byte;
   logic [3:0]          creditCnt;
   logic [3:0]          creditNext;
   logic                canSend;
   logic                overrunFlag;
   logic                rxErrFlag;
   logic                statusPend;
   ethRxPkg::RxStatus_t statusReg;

   assign AssembledByte = {MRxD, lowNibble};   // Complete while ByteDone is high

   // Count as it will stand after this edge
   assign creditNext = creditCnt + {3'b000, CreditReturn} - {3'b000, RxValid};
   assign canSend    = (creditNext != 4'd0);

   always_ff @(posedge MRxClk)
   begin
      if (State == ethRxPkg::Data && !NibblePhase)
         lowNibble <= MRxD;
      if (ByteDone)
         stage1Byte <= '{data: AssembledByte, startFrm: (ByteCnt == '0)};
      if (FrameEnd)
         statusReg <= '{crcError: !CrcOk, addressMiss: AddrMiss, overrun: overrunFlag,
                        rxErr: rxErrFlag, tooLong: TooLong, byteCount: ByteCnt};
   end

   ////////////////////
   // Byte pipeline
   ////////////////////

   always_ff @(posedge MRxClk or negedge Resetn)
   begin
      if (!Resetn)
      begin
         stage1Valid <= 1'b0;
         RxValid     <= 1'b0;
         RxByte      <= '0;
         creditCnt   <= ethRxPkg::RxCredits;
         overrunFlag <= 1'b0;
         rxErrFlag   <= 1'b0;
      end
      else
      begin
         stage1Valid <= ByteDone;
         creditCnt   <= creditNext;
         if (stage1Valid && canSend)
         begin
            RxValid <= 1'b1;
            RxByte  <= stage1Byte;
         end
         else
         begin
            RxValid         <= 1'b0;
            RxByte.startFrm <= 1'b0;
         end

         if (State == ethRxPkg::Preamble)
         begin
            overrunFlag <= 1'b0;   // New frame
            rxErrFlag   <= 1'b0;
         end
         else
         begin
            if (stage1Valid && !canSend)
               overrunFlag <= 1'b1;   // Byte lost
            if (State == ethRxPkg::Data && MRxErr)
               rxErrFlag <= 1'b1;
         end
      end
   end

   ////////////////////
   // Status
   ////////////////////

   always_ff @(posedge MRxClk or negedge Resetn)
   begin
      if (!Resetn)
      begin
         statusPend  <= 1'b0;
         StatusValid <= 1'b0;
         RxStatus    <= '0;
      end
      else
      begin
         statusPend  <= FrameEnd;
         StatusValid <= statusPend;
         if (statusPend)
            RxStatus <= statusReg;
      end
   end

endmodule

/* src/ethRxMac.sv */
/*
   Top level of the MII receive MAC. Connects the state machine, the byte
   counter, CRC check, address filter and the credit-controlled byte stream.
*/
`timescale 1ns/1ps

module ethRxMac (
   input  logic                MRxClk,
   input  logic                Resetn,
   input  logic                MRxDV,
   input  logic [3:0]          MRxD,
   input  logic                MRxErr,
   input  logic [47:0]         Mac,            // First byte on the wire in bits 7:0
   input  logic                Promiscuous,
   input  logic                BroadcastDisable,
   input  logic                CreditReturn,   // One pulse per freed byte
   output logic                RxValid,
   output ethRxPkg::RxByte_t   RxByte,
   output logic                StatusValid,
   output ethRxPkg::RxStatus_t RxStatus
);

   ethRxPkg::RxState_t   State;
   ethRxPkg::ByteCount_t ByteCnt;
   logic                 FrameEnd;
   logic                 TooLong;
   logic                 NibblePhase;
   logic                 ByteDone;
   logic                 CrcOk;
   logic                 AddrMiss;
   logic [7:0]           AssembledByte;

   rxStateMachine stateMachine (
      .MRxClk(MRxClk), .Resetn(Resetn), .MRxDV(MRxDV), .MRxD(MRxD),
      .MRxErr(MRxErr), .ByteCnt(ByteCnt), .State(State),
      .FrameEnd(FrameEnd), .TooLong(TooLong)
   );

   rxByteCounter byteCounter (
      .MRxClk(MRxClk), .Resetn(Resetn), .MRxDV(MRxDV), .State(State),
      .NibblePhase(NibblePhase), .ByteDone(ByteDone), .ByteCnt(ByteCnt)
   );

   rxCrcCheck crcCheck (
      .MRxClk(MRxClk), .Resetn(Resetn), .MRxD(MRxD), .MRxDV(MRxDV),
      .State(State), .CrcOk(CrcOk)
   );

   rxAddressFilter addressFilter (
      .MRxClk(MRxClk), .Resetn(Resetn), .State(State), .ByteDone(ByteDone),
      .ByteCnt(ByteCnt), .AssembledByte(AssembledByte), .Mac(Mac),
      .Promiscuous(Promiscuous), .BroadcastDisable(BroadcastDisable),
      .AddrMiss(AddrMiss)
   );

   // Output side, two register stages for bytes and for status
   rxByteStream byteStream (
      .MRxClk(MRxClk), .Resetn(Resetn), .MRxD(MRxD), .MRxErr(MRxErr),
      .State(State), .NibblePhase(NibblePhase), .ByteDone(ByteDone),
      .ByteCnt(ByteCnt), .FrameEnd(FrameEnd), .CrcOk(CrcOk),
      .AddrMiss(AddrMiss), .TooLong(TooLong), .CreditReturn(CreditReturn),
      .AssembledByte(AssembledByte), .RxValid(RxValid), .RxByte(RxByte),
      .StatusValid(StatusValid), .RxStatus(RxStatus)
   );

endmodule

/* bench/ethRxMac_checker.sv */
/*
   Protocol checks on the output side of the receive MAC, bound into
   rxByteStream so the credit count is visible.
*/
`timescale 1ns/1ps

module ethRxMac_checker (
   input logic                MRxClk,
   input logic                Resetn,
   input ethRxPkg::RxState_t  State,
   input logic                RxValid,
   input ethRxPkg::RxByte_t   RxByte,
   input logic                StatusValid,
   input ethRxPkg::RxStatus_t RxStatus,
   input logic [3:0]          creditCnt
);

   // A byte only leaves against a credit
   noByteWithoutCredit: assert property (@(posedge MRxClk) disable iff (!Resetn)
      RxValid |-> creditCnt != 4'd0)
      else $error("RxValid fired while no credit was left");

   startOnlyWithValid: assert property (@(posedge MRxClk) disable iff (!Resetn)
      RxByte.startFrm |-> RxValid)
      else $error("startFrm was high without RxValid");

   statusSinglePulse: assert property (@(posedge MRxClk) disable iff (!Resetn)
      StatusValid |=> !StatusValid)
      else $error("StatusValid stayed high for more than one cycle");

   // First edge out of reset
   quietAfterReset: assert property (@(posedge MRxClk)
      $rose(Resetn) |-> !RxValid && !StatusValid && RxByte == '0 && RxStatus == '0
                        && creditCnt == ethRxPkg::RxCredits && State == ethRxPkg::Idle)
      else $error("Outputs, state or credit count not at reset values after reset");

endmodule

bind rxByteStream ethRxMac_checker streamChecks (
   .MRxClk(MRxClk), .Resetn(Resetn), .State(State), .RxValid(RxValid),
   .RxByte(RxByte), .StatusValid(StatusValid), .RxStatus(RxStatus),
   .creditCnt(creditCnt)
);

/* bench/ethRxMacTb.sv */
/*
   Testbench for the MII receive MAC. Sends built frames into the DUT, returns
   credits like a consumer would, and checks every byte and status word.
*/
`timescale 1ns/1ps

module ethRxMacTb;

   typedef logic [7:0] byteQueue_t[$];

   logic                MRxClk = 1'b0;
   logic                Resetn = 1'b0;
   logic                MRxDV = 1'b0;
   logic [3:0]          MRxD = 4'h0;
   logic                MRxErr = 1'b0;
   logic [47:0]         Mac = 48'hBC9A_7856_3412;   // 12 goes first on the wire
   logic                Promiscuous = 1'b0;
   logic                BroadcastDisable = 1'b0;
   logic                CreditReturn = 1'b0;
   logic                RxValid;
   ethRxPkg::RxByte_t   RxByte;
   logic                StatusValid;
   ethRxPkg::RxStatus_t RxStatus;

   integer              seed = 54;
   int                  cycleCnt = 0;
   int                  creditDelay = 3;       // Cycles from byte to returned credit
   logic                holdCredits = 1'b0;
   int                  creditDue[$];
   ethRxPkg::RxByte_t   rxBytes[$];
   byteQueue_t          txBytes;
   int                  statusCount = 0;
   ethRxPkg::RxStatus_t lastStatus;

   ethRxMac dut (.*);

   always #2 MRxClk = ~MRxClk;

   ////////////////////
   // Consumer
   ////////////////////

   always @(posedge MRxClk)
   begin
      cycleCnt <= cycleCnt + 1;
      if (creditDue.size() > 0 && !holdCredits && creditDue[0] <= cycleCnt)
      begin
         CreditReturn <= 1'b1;   // One credit per cycle at most
         void'(creditDue.pop_front());
      end
      else
         CreditReturn <= 1'b0;
   end

   always @(negedge MRxClk)   // DUT outputs settled
   begin
      if (RxValid)
      begin
         rxBytes.push_back(RxByte);
         creditDue.push_back(cycleCnt + creditDelay);
      end
      if (StatusValid)
      begin
         lastStatus = RxStatus;
         statusCount++;
      end
   end

   // Ethernet FCS, reflected CRC-32, low byte sent first
   function automatic logic [31:0] fcsOf(input byteQueue_t bytes);
      logic [31:0] crc;
      crc = '1;
      foreach (bytes[i])
      begin
         crc = crc ^ {24'h0, bytes[i]};
         for (int b = 0; b < 8; b++)
            crc = crc[0] ? ((crc >> 1) ^ 32'hEDB88320) : (crc >> 1);
      end
      return ~crc;
   endfunction

   function automatic logic missExpected(input logic [47:0] dest);
      return !(dest == Mac || (dest == '1 && !BroadcastDisable) || Promiscuous);
   endfunction

   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("Finished with errors");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic driveNibble(input logic [3:0] nib, input logic err);
      @(posedge MRxClk);
      MRxDV  <= 1'b1;
      MRxD   <= nib;
      MRxErr <= err;
   endtask

   task automatic setFilter(input logic promisc, input logic bcastDisable);
      @(posedge MRxClk);
      Promiscuous      <= promisc;
      BroadcastDisable <= bcastDisable;
      @(posedge MRxClk);
   endtask

   ////////////////////
   // Frame builder
   ////////////////////

   task automatic sendFrame(input logic [47:0] dest, input int payloadLen, input bit badFcs,
                            input int errNibble, input int badPreambleAt);
      logic [31:0] fcs;
      logic [31:0] rnd;
      txBytes.delete();
      rxBytes.delete();
      for (int i = 0; i < 6; i++)
         txBytes.push_back(dest[8*i +: 8]);
      for (int i = 0; i < payloadLen; i++)
      begin
         rnd = $random(seed);
         txBytes.push_back(rnd[7:0]);
      end
      fcs = fcsOf(txBytes);
      if (badFcs)
         fcs[0] = ~fcs[0];
      for (int i = 0; i < 4; i++)
         txBytes.push_back(fcs[8*i +: 8]);
      for (int i = 0; i < 15; i++)
         driveNibble((i == badPreambleAt) ? 4'h7 : ethRxPkg::PreambleNibble, 1'b0);
      driveNibble(ethRxPkg::SfdNibble, 1'b0);
      foreach (txBytes[i])
      begin
         driveNibble(txBytes[i][3:0], (2*i == errNibble));   // Low nibble first
         driveNibble(txBytes[i][7:4], 1'b0);
      end
      @(posedge MRxClk);
      MRxDV <= 1'b0;
      MRxD  <= 4'h0;
   endtask

   task automatic waitForStatus(input int prevCount);
      int n;
      n = 0;
      while (statusCount == prevCount && n < 100)
      begin
         @(posedge MRxClk);
         n++;
      end
      if (statusCount == prevCount)
         abortRun("Timed out waiting for the frame status");
   endtask

   task automatic drainCredits();
      int n;
      n = 0;
      holdCredits <= 1'b0;
      while (creditDue.size() > 0 && n < 200)
      begin
         @(posedge MRxClk);
         n++;
      end
      if (creditDue.size() > 0)
         abortRun("Credits were not handed back to the DUT in time");
      for (int i = 0; i < 4; i++)
         @(posedge MRxClk);   // Gap between frames
   endtask

   // Expected results follow from frame length, FCS, filter and credit rules
   task automatic checkFrame(input logic [47:0] dest, input int payloadLen, input bit badFcs,
                             input int errNibble);
      int                  maxLen = int'(ethRxPkg::MaxFrameLen);
      int                  total = payloadLen + 10;
      int                  counted = (total > maxLen) ? maxLen : total;
      int                  delivered = counted;
      int                  prevCount = statusCount;
      ethRxPkg::RxStatus_t expStatus;
      if (holdCredits && delivered > int'(ethRxPkg::RxCredits))
         delivered = int'(ethRxPkg::RxCredits);
      expStatus = '{crcError: badFcs || (total > maxLen), addressMiss: missExpected(dest),
                    overrun: holdCredits && (total > int'(ethRxPkg::RxCredits)),
                    rxErr: (errNibble >= 0), tooLong: (total > maxLen),
                    byteCount: 16'(counted)};
      sendFrame(dest, payloadLen, badFcs, errNibble, -1);
      waitForStatus(prevCount);
      assert (rxBytes.size() == delivered)
         else abortRun($sformatf("Error at %0t ns: %0d bytes received, expected %0d",
                                 $time, rxBytes.size(), delivered));
      foreach (rxBytes[i])
         assert (rxBytes[i].data == txBytes[i] && rxBytes[i].startFrm == (i == 0))
            else abortRun($sformatf("Error at %0t ns: byte %0d is %h/%b, expected %h",
                                    $time, i, rxBytes[i].data, rxBytes[i].startFrm,
                                    txBytes[i]));
      assert (lastStatus == expStatus)
         else abortRun($sformatf("Error at %0t ns: status %h, expected %h",
                                 $time, lastStatus, expStatus));
      drainCredits();
   endtask

   initial
   begin
      int prevCount;
      for (int i = 0; i < 3; i++)
         @(posedge MRxClk);
      Resetn <= 1'b1;
      for (int i = 0; i < 4; i++)
         @(posedge MRxClk);

      checkFrame(Mac, 46, 1'b0, -1);
      checkFrame(Mac, 60, 1'b1, -1);                  // Corrupted FCS

      // Address filter
      checkFrame(48'hBC9A_7856_3413, 46, 1'b0, -1);
      checkFrame(48'hFFFF_FFFF_FFFF, 46, 1'b0, -1);
      setFilter(1'b0, 1'b1);
      checkFrame(48'hFFFF_FFFF_FFFF, 46, 1'b0, -1);
      setFilter(1'b1, 1'b1);
      checkFrame(48'hBC9A_7856_3413, 46, 1'b0, -1);
      setFilter(1'b0, 1'b0);

      // Consumer keeps every credit until the frame is over
      creditDelay = 5;
      holdCredits <= 1'b1;
      @(posedge MRxClk);
      checkFrame(Mac, 46, 1'b0, -1);

      // Bad preamble nibble, the frame must vanish
      prevCount = statusCount;
      sendFrame(Mac, 46, 1'b0, -1, 5);
      for (int i = 0; i < 20; i++)
         @(posedge MRxClk);
      assert (rxBytes.size() == 0 && statusCount == prevCount)
         else abortRun($sformatf("Error at %0t ns: dropped frame produced %0d bytes",
                                 $time, rxBytes.size()));

      checkFrame(Mac, 46, 1'b0, 40);                  // MRxErr in the payload
      creditDelay = 1;
      checkFrame(Mac, 1520, 1'b0, -1);                // Past the length limit

      $display("Finished with no errors");
      $finish;
   end

endmodule

/* compile.f */
src/ethRxPkg.sv
src/rxStateMachine.sv
src/rxByteCounter.sv
src/rxCrcCheck.sv
src/rxAddressFilter.sv
src/rxByteStream.sv
src/ethRxMac.sv
bench/ethRxMac_checker.sv
bench/ethRxMacTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the receive MAC testbench with Verilator and runs it.
# The exit status is the simulation's own status.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module ethRxMacTb \
      -f compile.f --Mdir obj_dir -o ethRxMacSim; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/ethRxMacSim
status=$?
if [ "$status" -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit "$status"
fi

exit 0
